// ==== source/pcie_ss_pkg.sv ====
/* PCIe SS interface shared definitions
   Feature header, host register map, error codes and TLP DW1 views */
`default_nettype none

package pcie_ss_pkg;

   // --------------------------------------------------
   // Feature header
   // --------------------------------------------------
   localparam logic [11:0] FEAT_ID         = 12'h010;
   localparam logic [3:0]  FEAT_VER        = 4'h1;
   localparam logic [23:0] NEXT_DFH_OFFSET = 24'h001000;
   localparam logic        END_OF_LIST     = 1'b0;

   // 32-bit header word, offset keeps its low 15 bits
   localparam logic [31:0] DFH_WORD =
      {END_OF_LIST, NEXT_DFH_OFFSET[14:0], FEAT_VER, FEAT_ID};

   // --------------------------------------------------
   // Host register map
   // --------------------------------------------------
   localparam int CSR_ADDR_W = 8;

   localparam logic [CSR_ADDR_W-1:0] REG_DFH      = 8'h00;
   localparam logic [CSR_ADDR_W-1:0] REG_STATUS   = 8'h04;
   localparam logic [CSR_ADDR_W-1:0] REG_RX_ERR   = 8'h08;
   localparam logic [CSR_ADDR_W-1:0] REG_ERR_CODE = 8'h0C;
   localparam logic [CSR_ADDR_W-1:0] REG_ERR_HDR0 = 8'h10;
   localparam logic [CSR_ADDR_W-1:0] REG_ERR_HDR1 = 8'h14;
   localparam logic [CSR_ADDR_W-1:0] REG_SS_ADDR  = 8'h18;
   localparam logic [CSR_ADDR_W-1:0] REG_SS_WDATA = 8'h1C;
   localparam logic [CSR_ADDR_W-1:0] REG_SS_CMD   = 8'h20;
   localparam logic [CSR_ADDR_W-1:0] REG_SS_RDATA = 8'h24;

   // SS register port
   localparam int                   SS_ADDR_W       = 16;
   localparam logic [SS_ADDR_W-1:0] SS_ERR_LOG_ADDR = 16'h0100;

   localparam logic [1:0] SS_CMD_NONE = 2'd0;
   localparam logic [1:0] SS_CMD_RD   = 2'd1;
   localparam logic [1:0] SS_CMD_WR   = 2'd2;

   // Error code bit positions
   localparam int ERR_W              = 4;
   localparam int ERR_BAD_CPL_STATUS = 0;
   localparam int ERR_BAD_BYTE_EN    = 1;
   localparam int ERR_UNSUP_TYPE     = 2;
   localparam int ERR_CPL_TIMEOUT    = 3;

   localparam int PF_W = 3;

   // TLP type codes, fmt[2] must be clear for both
   localparam logic [4:0] TYPE_MEM = 5'b00000;
   localparam logic [4:0] TYPE_CPL = 5'b01010;
   localparam logic [2:0] CPL_SC   = 3'b000;

   // Header DW1, request or completion view
   typedef union packed {
      struct packed {
         logic [15:0] req_id;
         logic [7:0]  tag;
         logic [3:0]  last_be;
         logic [3:0]  first_be;
      } req;
      struct packed {
         logic [15:0] cpl_id;
         logic [2:0]  status;
         logic        bcm;
         logic [11:0] byte_count;
      } cpl;
   } t_tlp_dw1;

endpackage : pcie_ss_pkg

`default_nettype wire

// ==== source/pcie_csr.sv ====
/* PCIe SS host register block
   Feature header, status, sticky error log and indirect SS commands */
`default_nettype none

module pcie_csr (
   input  logic                               csr_clk,
   input  logic                               i_arst_n,
   // Host access
   input  logic                               i_csr_wr,
   input  logic                               i_csr_rd,
   input  logic [pcie_ss_pkg::CSR_ADDR_W-1:0] i_csr_addr,
   input  logic [31:0]                        i_csr_wdata,
   output logic [31:0]                        o_csr_rdata,
   output logic                               o_csr_rvalid,
   // Status inputs
   input  logic                               i_pcie_linkup,
   input  logic [31:0]                        i_rx_err_code,
   // Error reports
   input  logic                               i_err_valid,
   input  logic [pcie_ss_pkg::ERR_W-1:0]      i_err_code,
   input  logic [31:0]                        i_err_hdr0,
   input  logic [31:0]                        i_err_hdr1,
   // Indirect SS command
   output logic [1:0]                         o_ss_cmd,
   output logic [pcie_ss_pkg::SS_ADDR_W-1:0]  o_ss_addr,
   output logic [31:0]                        o_ss_wdata,
   input  logic                               i_ss_done,
   input  logic [31:0]                        i_ss_rdata,
   input  logic                               i_ss_resp_err
);
   import pcie_ss_pkg::*;

   logic [ERR_W-1:0]     err_code_q;
   logic [31:0]          err_hdr0_q;
   logic [31:0]          err_hdr1_q;
   logic [SS_ADDR_W-1:0] ss_addr_q;
   logic [31:0]          ss_wdata_q;
   logic [31:0]          ss_rdata_q;
   logic [1:0]           ss_cmd_q;
   logic                 busy_q;
   logic                 ss_err_q;
   logic                 cmd_ok;

   // Only read and write codes start a transaction
   assign cmd_ok = (i_csr_wdata[1:0] == SS_CMD_RD) || (i_csr_wdata[1:0] == SS_CMD_WR);

   // --------------------------------------------------
   // Control, status and error log
   // --------------------------------------------------
   always_ff @(posedge csr_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         err_code_q <= '0;
         err_hdr0_q <= '0;
         err_hdr1_q <= '0;
         ss_cmd_q   <= SS_CMD_NONE;
         busy_q     <= 1'b0;
         ss_err_q   <= 1'b0;
      end else begin
         // W1C and new report may land together
         if (i_csr_wr && (i_csr_addr == REG_ERR_CODE)) begin
            err_code_q <= (err_code_q & ~i_csr_wdata[ERR_W-1:0]) |
                          (i_err_valid ? i_err_code : '0);
         end else if (i_err_valid) begin
            err_code_q <= err_code_q | i_err_code;
         end
         // Header of the first error only
         if (i_err_valid && (err_code_q == '0)) begin
            err_hdr0_q <= i_err_hdr0;
            err_hdr1_q <= i_err_hdr1;
         end

         if (i_csr_wr && (i_csr_addr == REG_SS_CMD) && !busy_q && cmd_ok) begin
            ss_cmd_q <= i_csr_wdata[1:0];
            busy_q   <= 1'b1;
         end else if (i_ss_done) begin
            ss_cmd_q <= SS_CMD_NONE;
            busy_q   <= 1'b0;
         end

         if (i_ss_done && i_ss_resp_err) begin
            ss_err_q <= 1'b1;
         end else if (i_csr_wr && (i_csr_addr == REG_STATUS) && i_csr_wdata[2]) begin
            ss_err_q <= 1'b0;
         end
      end
   end

   // Indirect payload
   always_ff @(posedge csr_clk) begin
      if (i_csr_wr && (i_csr_addr == REG_SS_ADDR)) ss_addr_q <= i_csr_wdata[SS_ADDR_W-1:0];
      if (i_csr_wr && (i_csr_addr == REG_SS_WDATA)) ss_wdata_q <= i_csr_wdata;
      if (i_ss_done) ss_rdata_q <= i_ss_rdata;
   end

   // --------------------------------------------------
   // Read path, one cycle
   // --------------------------------------------------
   always_ff @(posedge csr_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         o_csr_rvalid <= 1'b0;
         o_csr_rdata  <= '0;
      end else begin
         o_csr_rvalid <= i_csr_rd;
         if (i_csr_rd) begin
            case (i_csr_addr)
               REG_DFH:      o_csr_rdata <= DFH_WORD;
               REG_STATUS:   o_csr_rdata <= {29'h0, ss_err_q, busy_q, i_pcie_linkup};
               REG_RX_ERR:   o_csr_rdata <= i_rx_err_code;
               REG_ERR_CODE: o_csr_rdata <= {{(32-ERR_W){1'b0}}, err_code_q};
               REG_ERR_HDR0: o_csr_rdata <= err_hdr0_q;
               REG_ERR_HDR1: o_csr_rdata <= err_hdr1_q;
               REG_SS_ADDR:  o_csr_rdata <= {{(32-SS_ADDR_W){1'b0}}, ss_addr_q};
               REG_SS_WDATA: o_csr_rdata <= ss_wdata_q;
               REG_SS_CMD:   o_csr_rdata <= {30'h0, ss_cmd_q};
               REG_SS_RDATA: o_csr_rdata <= ss_rdata_q;
               default:      o_csr_rdata <= '0;
            endcase
         end
      end
   end

   assign o_ss_cmd   = ss_cmd_q;
   assign o_ss_addr  = ss_addr_q;
   assign o_ss_wdata = ss_wdata_q;

   // Master completes only what was issued
   a_done_when_busy : assert property (@(posedge csr_clk) disable iff (!i_arst_n)
      i_ss_done |-> busy_q);

   a_read_response : assert property (@(posedge csr_clk) disable iff (!i_arst_n)
      i_csr_rd |=> o_csr_rvalid);

endmodule : pcie_csr

`default_nettype wire

// ==== source/pcie_err_checker.sv ====
/* PCIe transmit error checker
   Turns bad TLP headers and completion timeouts into error reports */
`default_nettype none

module pcie_err_checker (
   input  logic                          csr_clk,
   input  logic                          i_arst_n,
   input  logic                          i_tx_valid,
   input  logic                          i_tx_ready,
   input  logic [31:0]                   i_tx_hdr_dw0,
   input  logic [31:0]                   i_tx_hdr_dw1,
   input  logic [pcie_ss_pkg::PF_W-1:0]  i_tx_pf,
   input  logic                          i_cpl_timeout,
   input  logic [7:0]                    i_cpl_timeout_tag,
   output logic                          o_err_valid,
   output logic [pcie_ss_pkg::ERR_W-1:0] o_err_code,
   output logic [31:0]                   o_err_hdr0,
   output logic [31:0]                   o_err_hdr1,
   output logic [pcie_ss_pkg::PF_W-1:0]  o_err_pf
);
   import pcie_ss_pkg::*;

   logic [2:0]       fmt;
   logic [4:0]       tlp_type;
   logic [9:0]       length;
   t_tlp_dw1         dw1;
   logic             beat;
   logic             is_mem;
   logic             is_cpl;
   logic [ERR_W-1:0] beat_code;
   logic [ERR_W-1:0] code_nxt;

   // DW0 fields
   assign fmt      = i_tx_hdr_dw0[31:29];
   assign tlp_type = i_tx_hdr_dw0[28:24];
   assign length   = i_tx_hdr_dw0[9:0];
   assign dw1      = i_tx_hdr_dw1;

   assign beat   = i_tx_valid && i_tx_ready;
   assign is_mem = (tlp_type == TYPE_MEM) && !fmt[2];
   // Cpl or CplD only
   assign is_cpl = (tlp_type == TYPE_CPL) && !fmt[2] && !fmt[0];

   // --------------------------------------------------
   // Header rules
   // --------------------------------------------------
   always_comb begin
      beat_code = '0;
      if (beat) begin
         beat_code[ERR_UNSUP_TYPE]     = !is_mem && !is_cpl;
         beat_code[ERR_BAD_CPL_STATUS] = is_cpl && (dw1.cpl.status != CPL_SC);
         beat_code[ERR_BAD_BYTE_EN]    = is_mem && (length == 10'd1) &&
                                         (dw1.req.last_be != 4'h0);
      end
      code_nxt = beat_code;
      code_nxt[ERR_CPL_TIMEOUT] = i_cpl_timeout;
   end

   always_ff @(posedge csr_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         o_err_valid <= 1'b0;
         o_err_code  <= '0;
      end else begin
         o_err_valid <= |code_nxt;
         o_err_code  <= code_nxt;
      end
   end

   // Bad beat header wins, timeout alone carries its tag
   always_ff @(posedge csr_clk) begin
      if (|beat_code) begin
         o_err_hdr0 <= i_tx_hdr_dw0;
         o_err_hdr1 <= i_tx_hdr_dw1;
         o_err_pf   <= i_tx_pf;
      end else if (i_cpl_timeout) begin
         o_err_hdr0 <= '0;
         o_err_hdr1 <= {24'h0, i_cpl_timeout_tag};
         o_err_pf   <= '0;
      end
   end

   a_report_has_code : assert property (@(posedge csr_clk) disable iff (!i_arst_n)
      o_err_valid |-> (o_err_code != '0));

endmodule : pcie_err_checker

`default_nettype wire

// ==== source/pcie_ss_csr_master.sv ====
/* PCIe SS register port master
   Error-log writes first, then host indirect commands */
`default_nettype none

module pcie_ss_csr_master (
   input  logic                              csr_clk,
   input  logic                              i_arst_n,
   // Error reports
   input  logic                              i_err_valid,
   input  logic [pcie_ss_pkg::ERR_W-1:0]     i_err_code,
   input  logic [pcie_ss_pkg::PF_W-1:0]      i_err_pf,
   // Host indirect command
   input  logic [1:0]                        i_ss_cmd,
   input  logic [pcie_ss_pkg::SS_ADDR_W-1:0] i_ss_addr,
   input  logic [31:0]                       i_ss_wdata,
   output logic                              o_ss_done,
   output logic [31:0]                       o_ss_rdata,
   output logic                              o_ss_resp_err,
   // SS register port
   output logic                              o_ss_req,
   output logic                              o_ss_wr,
   output logic [pcie_ss_pkg::SS_ADDR_W-1:0] o_ss_addr,
   output logic [31:0]                       o_ss_wdata,
   input  logic                              i_ss_ack,
   input  logic [31:0]                       i_ss_rdata,
   input  logic                              i_ss_resp_err
);
   import pcie_ss_pkg::*;

   logic             cur_err_q;
   logic             buf_valid_q;
   logic [ERR_W-1:0] buf_code_q;
   logic [PF_W-1:0]  buf_pf_q;
   logic             err_launch;
   logic             host_launch;
   logic             buf_load;
   logic [ERR_W-1:0] log_code;
   logic [PF_W-1:0]  log_pf;

   // Idle when o_ss_req is low; buffered report before a fresh one
   assign err_launch  = !o_ss_req && (buf_valid_q || i_err_valid);
   // Hold off while the previous done is still visible to the host block
   assign host_launch = !o_ss_req && !err_launch && !o_ss_done && (i_ss_cmd != SS_CMD_NONE);
   assign buf_load    = i_err_valid && (buf_valid_q ? err_launch : !err_launch);
   assign log_code    = buf_valid_q ? buf_code_q : i_err_code;
   assign log_pf      = buf_valid_q ? buf_pf_q : i_err_pf;

   // --------------------------------------------------
   // Request FSM and error buffer
   // --------------------------------------------------
   always_ff @(posedge csr_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         o_ss_req    <= 1'b0;
         cur_err_q   <= 1'b0;
         buf_valid_q <= 1'b0;
         o_ss_done   <= 1'b0;
      end else begin
         o_ss_done <= o_ss_req && i_ss_ack && !cur_err_q;
         if (o_ss_req && i_ss_ack) begin
            o_ss_req <= 1'b0;
         end else if (err_launch || host_launch) begin
            o_ss_req  <= 1'b1;
            cur_err_q <= err_launch;
         end
         if (buf_load) begin
            buf_valid_q <= 1'b1;
         end else if (err_launch) begin
            buf_valid_q <= 1'b0;
         end
      end
   end

   always_ff @(posedge csr_clk) begin
      if (buf_load) begin
         buf_code_q <= i_err_code;
         buf_pf_q   <= i_err_pf;
      end
      if (err_launch) begin
         o_ss_wr    <= 1'b1;
         o_ss_addr  <= SS_ERR_LOG_ADDR;
         o_ss_wdata <= {{(32-PF_W-ERR_W){1'b0}}, log_pf, log_code};
      end else if (host_launch) begin
         o_ss_wr    <= (i_ss_cmd == SS_CMD_WR);
         o_ss_addr  <= i_ss_addr;
         o_ss_wdata <= i_ss_wdata;
      end
      if (o_ss_req && i_ss_ack) begin
         o_ss_rdata    <= i_ss_rdata;
         o_ss_resp_err <= i_ss_resp_err;
      end
   end

   a_req_stable : assert property (@(posedge csr_clk) disable iff (!i_arst_n)
      (o_ss_req && !i_ss_ack) |=> o_ss_req && $stable({o_ss_wr, o_ss_addr, o_ss_wdata}));

endmodule : pcie_ss_csr_master

`default_nettype wire

// ==== source/pcie_ss_if.sv ====
/* PCIe SS interface top level
   Host register window, transmit error checker and SS register master */
`default_nettype none

module pcie_ss_if (
   input  logic                               csr_clk,
   input  logic                               i_arst_n,
   // Host register window
   input  logic                               i_csr_wr,
   input  logic                               i_csr_rd,
   input  logic [pcie_ss_pkg::CSR_ADDR_W-1:0] i_csr_addr,
   input  logic [31:0]                        i_csr_wdata,
   output logic [31:0]                        o_csr_rdata,
   output logic                               o_csr_rvalid,
   // Transmit monitor
   input  logic                               i_tx_valid,
   input  logic                               i_tx_ready,
   input  logic [31:0]                        i_tx_hdr_dw0,
   input  logic [31:0]                        i_tx_hdr_dw1,
   input  logic [pcie_ss_pkg::PF_W-1:0]       i_tx_pf,
   input  logic                               i_cpl_timeout,
   input  logic [7:0]                         i_cpl_timeout_tag,
   // Status
   input  logic                               i_pcie_linkup,
   input  logic [31:0]                        i_rx_err_code,
   // SS register port
   output logic                               o_ss_req,
   output logic                               o_ss_wr,
   output logic [pcie_ss_pkg::SS_ADDR_W-1:0]  o_ss_addr,
   output logic [31:0]                        o_ss_wdata,
   input  logic                               i_ss_ack,
   input  logic [31:0]                        i_ss_rdata,
   input  logic                               i_ss_resp_err
);
   import pcie_ss_pkg::*;

   logic                 err_valid;
   logic [ERR_W-1:0]     err_code;
   logic [31:0]          err_hdr0;
   logic [31:0]          err_hdr1;
   logic [PF_W-1:0]      err_pf;
   logic [1:0]           ss_cmd;
   logic [SS_ADDR_W-1:0] ss_addr;
   logic [31:0]          ss_wdata;
   logic                 ss_done;
   logic [31:0]          ss_rdata;
   logic                 ss_resp_err;

   pcie_csr u_csr (
      .csr_clk       (csr_clk),
      .i_arst_n      (i_arst_n),
      .i_csr_wr      (i_csr_wr),
      .i_csr_rd      (i_csr_rd),
      .i_csr_addr    (i_csr_addr),
      .i_csr_wdata   (i_csr_wdata),
      .o_csr_rdata   (o_csr_rdata),
      .o_csr_rvalid  (o_csr_rvalid),
      .i_pcie_linkup (i_pcie_linkup),
      .i_rx_err_code (i_rx_err_code),
      .i_err_valid   (err_valid),
      .i_err_code    (err_code),
      .i_err_hdr0    (err_hdr0),
      .i_err_hdr1    (err_hdr1),
      .o_ss_cmd      (ss_cmd),
      .o_ss_addr     (ss_addr),
      .o_ss_wdata    (ss_wdata),
      .i_ss_done     (ss_done),
      .i_ss_rdata    (ss_rdata),
      .i_ss_resp_err (ss_resp_err)
   );

   pcie_err_checker u_err_checker (
      .csr_clk           (csr_clk),
      .i_arst_n          (i_arst_n),
      .i_tx_valid        (i_tx_valid),
      .i_tx_ready        (i_tx_ready),
      .i_tx_hdr_dw0      (i_tx_hdr_dw0),
      .i_tx_hdr_dw1      (i_tx_hdr_dw1),
      .i_tx_pf           (i_tx_pf),
      .i_cpl_timeout     (i_cpl_timeout),
      .i_cpl_timeout_tag (i_cpl_timeout_tag),
      .o_err_valid       (err_valid),
      .o_err_code        (err_code),
      .o_err_hdr0        (err_hdr0),
      .o_err_hdr1        (err_hdr1),
      .o_err_pf          (err_pf)
   );

   // Shared SS port for error logging and host indirect access
   pcie_ss_csr_master u_ss_master (
      .csr_clk       (csr_clk),
      .i_arst_n      (i_arst_n),
      .i_err_valid   (err_valid),
      .i_err_code    (err_code),
      .i_err_pf      (err_pf),
      .i_ss_cmd      (ss_cmd),
      .i_ss_addr     (ss_addr),
      .i_ss_wdata    (ss_wdata),
      .o_ss_done     (ss_done),
      .o_ss_rdata    (ss_rdata),
      .o_ss_resp_err (ss_resp_err),
      .o_ss_req      (o_ss_req),
      .o_ss_wr       (o_ss_wr),
      .o_ss_addr     (o_ss_addr),
      .o_ss_wdata    (o_ss_wdata),
      .i_ss_ack      (i_ss_ack),
      .i_ss_rdata    (i_ss_rdata),
      .i_ss_resp_err (i_ss_resp_err)
   );

endmodule : pcie_ss_if

`default_nettype wire

// ==== tests/pcie_ss_model.sv ====
/* Behavioral SS register responder
   16 words, random ack delay, response error at 0x0200 and above */
`default_nettype none

module pcie_ss_model (
   input  logic        csr_clk,
   input  logic        i_arst_n,
   input  logic        i_req,
   input  logic        i_wr,
   input  logic [15:0] i_addr,
   input  logic [31:0] i_wdata,
   output logic        o_ack,
   output logic [31:0] o_rdata,
   output logic        o_resp_err
);
   timeunit 1ns;
   timeprecision 1ps;
   import pcie_ss_pkg::*;

   logic [31:0] mem [16];
   logic [31:0] err_log_word;
   logic        active;
   int unsigned ack_wait;

   always @(posedge csr_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         o_ack        <= 1'b0;
         o_rdata      <= '0;
         o_resp_err   <= 1'b0;
         active       <= 1'b0;
         ack_wait     <= 0;
         err_log_word <= '0;
         for (int i = 0; i < 16; i++) begin
            mem[i] <= '0;
         end
      end else begin
         o_ack <= 1'b0;
         if (!active) begin
            // New request only once the previous ack is gone
            if (i_req && !o_ack) begin
               active   <= 1'b1;
               ack_wait <= $urandom_range(3, 0);
            end
         end else if (ack_wait != 0) begin
            ack_wait <= ack_wait - 1;
         end else begin
            active     <= 1'b0;
            o_ack      <= 1'b1;
            o_resp_err <= (i_addr >= 16'h0200);
            if (i_wr) begin
               mem[i_addr[5:2]] <= i_wdata;
               if (i_addr == SS_ERR_LOG_ADDR) begin
                  err_log_word <= i_wdata;
               end
            end else begin
               o_rdata <= mem[i_addr[5:2]];
            end
         end
      end
   end

endmodule : pcie_ss_model

`default_nettype wire

// ==== tests/tb_pcie_ss_if.sv ====
/* Testbench for the PCIe SS interface
   Register window, TLP error checking and SS port against a behavioral SS */
`default_nettype none

module tb_pcie_ss_if;
   timeunit 1ns;
   timeprecision 1ps;
   import pcie_ss_pkg::*;

   logic        csr_clk;
   logic        i_arst_n;
   logic        i_csr_wr;
   logic        i_csr_rd;
   logic [7:0]  i_csr_addr;
   logic [31:0] i_csr_wdata;
   logic [31:0] o_csr_rdata;
   logic        o_csr_rvalid;
   logic        i_tx_valid;
   logic        i_tx_ready;
   logic [31:0] i_tx_hdr_dw0;
   logic [31:0] i_tx_hdr_dw1;
   logic [2:0]  i_tx_pf;
   logic        i_cpl_timeout;
   logic [7:0]  i_cpl_timeout_tag;
   logic        i_pcie_linkup;
   logic [31:0] i_rx_err_code;
   logic        o_ss_req;
   logic        o_ss_wr;
   logic [15:0] o_ss_addr;
   logic [31:0] o_ss_wdata;
   logic        i_ss_ack;
   logic [31:0] i_ss_rdata;
   logic        i_ss_resp_err;

   int          mismatches;
   int          problems;
   logic [15:0] acked_addr [$];

   pcie_ss_if i_dut (.*);

   pcie_ss_model u_ss (
      .csr_clk    (csr_clk),
      .i_arst_n   (i_arst_n),
      .i_req      (o_ss_req),
      .i_wr       (o_ss_wr),
      .i_addr     (o_ss_addr),
      .i_wdata    (o_ss_wdata),
      .o_ack      (i_ss_ack),
      .o_rdata    (i_ss_rdata),
      .o_resp_err (i_ss_resp_err)
   );

   initial begin
      csr_clk = 1'b0;
      forever #2 csr_clk = ~csr_clk;
   end

   // Order in which the SS saw transactions complete
   always @(posedge csr_clk) begin
      if (o_ss_req && i_ss_ack) begin
         acked_addr.push_back(o_ss_addr);
      end
   end

   task automatic report_mismatch(input string sig, input logic [31:0] got,
                                  input logic [31:0] exp);
      mismatches++;
      $display("FAILED at %0d ns: %s is 0x%h, expected 0x%h", $time, sig, got, exp);
   endtask

   task automatic log_failure(input string msg);
      problems++;
      $display("Error at %0d ns: %s", $time, msg);
   endtask

   task automatic expect_value(input string sig, input logic [31:0] got,
                               input logic [31:0] exp);
      assert (got === exp) else report_mismatch(sig, got, exp);
   endtask

   // --------------------------------------------------
   // Bus helpers, called and returning on a falling edge
   // --------------------------------------------------
   task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
      i_csr_wr    = 1'b1;
      i_csr_addr  = addr;
      i_csr_wdata = data;
      @(negedge csr_clk);
      i_csr_wr = 1'b0;
   endtask

   task automatic read_reg(input logic [7:0] addr, output logic [31:0] data);
      i_csr_rd   = 1'b1;
      i_csr_addr = addr;
      @(negedge csr_clk);
      i_csr_rd = 1'b0;
      data     = o_csr_rdata;
   endtask

   function automatic logic [31:0] make_dw0(input logic [2:0] fmt, input logic [4:0] tlp_type,
                                            input logic [9:0] len);
      return {fmt, tlp_type, 14'h0, len};
   endfunction

   // Beat plus one more cycle so the report reaches the log
   task automatic send_beat(input logic [31:0] dw0, input logic [31:0] dw1,
                            input logic [2:0] pf, input logic ready);
      i_tx_valid   = 1'b1;
      i_tx_ready   = ready;
      i_tx_hdr_dw0 = dw0;
      i_tx_hdr_dw1 = dw1;
      i_tx_pf      = pf;
      @(negedge csr_clk);
      i_tx_valid = 1'b0;
      i_tx_ready = 1'b1;
      @(negedge csr_clk);
   endtask

   task automatic wait_idle(input string what);
      logic [31:0] status;
      int          polls;
      polls = 0;
      read_reg(REG_STATUS, status);
      while (status[1] && polls < 100) begin
         read_reg(REG_STATUS, status);
         polls++;
      end
      assert (!status[1]) else log_failure({what, " still busy after the timeout"});
   endtask

   task automatic wait_log(input logic [31:0] exp);
      int cycles;
      cycles = 0;
      while (u_ss.err_log_word !== exp && cycles < 50) begin
         @(negedge csr_clk);
         cycles++;
      end
      assert (u_ss.err_log_word === exp)
         else log_failure($sformatf("error report 0x%h never reached the SS log", exp));
   endtask

   // --------------------------------------------------
   // Protocol checks
   // --------------------------------------------------
   a_rvalid_after_read : assert property (@(posedge csr_clk) disable iff (!i_arst_n)
      i_csr_rd |=> o_csr_rvalid) else report_mismatch("o_csr_rvalid", 32'd0, 32'd1);

   a_no_stray_rvalid : assert property (@(posedge csr_clk) disable iff (!i_arst_n)
      !i_csr_rd |=> !o_csr_rvalid) else report_mismatch("o_csr_rvalid", 32'd1, 32'd0);

   a_req_held : assert property (@(posedge csr_clk) disable iff (!i_arst_n)
      (o_ss_req && !i_ss_ack) |=> o_ss_req && $stable({o_ss_wr, o_ss_addr, o_ss_wdata}))
      else log_failure("SS request outputs changed before the ack");

   initial begin
      logic [31:0] rd;
      logic [31:0] rx_code;
      logic [31:0] cpl_dw0;
      logic [31:0] mem_dw0;
      logic [31:0] ss_data;
      logic [15:0] ss_addr;
      logic [2:0]  pf;
      logic [7:0]  tag;
      t_tlp_dw1    cpl_ur;
      t_tlp_dw1    req_be;
      int          acks_before;

      void'($urandom(74));
      mismatches        = 0;
      problems          = 0;
      i_arst_n          = 1'b0;
      i_csr_wr          = 1'b0;
      i_csr_rd          = 1'b0;
      i_csr_addr        = '0;
      i_csr_wdata       = '0;
      i_tx_valid        = 1'b0;
      i_tx_ready        = 1'b1;
      i_tx_hdr_dw0      = '0;
      i_tx_hdr_dw1      = '0;
      i_tx_pf           = '0;
      i_cpl_timeout     = 1'b0;
      i_cpl_timeout_tag = '0;
      i_pcie_linkup     = 1'b1;
      rx_code           = $urandom();
      i_rx_err_code     = rx_code;
      repeat (16) @(negedge csr_clk);
      i_arst_n = 1'b1;
      @(negedge csr_clk);

      // Reset state and local registers
      expect_value("o_ss_req", o_ss_req, 0);
      expect_value("o_csr_rvalid", o_csr_rvalid, 0);
      read_reg(REG_DFH, rd);
      expect_value("REG_DFH", rd, {END_OF_LIST, NEXT_DFH_OFFSET[14:0], FEAT_VER, FEAT_ID});
      read_reg(REG_STATUS, rd);
      expect_value("REG_STATUS.linkup", rd[0], 1);
      i_pcie_linkup = 1'b0;
      read_reg(REG_STATUS, rd);
      expect_value("REG_STATUS.linkup", rd[0], 0);
      i_pcie_linkup = 1'b1;
      read_reg(REG_RX_ERR, rd);
      expect_value("REG_RX_ERR", rd, rx_code);

      // Header beats, UR completion and length-1 write with last BE set
      cpl_ur                 = '0;
      cpl_ur.cpl.cpl_id      = 16'h0008;
      cpl_ur.cpl.status      = 3'b001;
      cpl_ur.cpl.byte_count  = 12'd4;
      cpl_dw0                = make_dw0(3'b010, TYPE_CPL, 10'd1);
      req_be                 = '0;
      req_be.req.req_id      = 16'h0010;
      req_be.req.tag         = 8'h21;
      req_be.req.last_be     = 4'h3;
      req_be.req.first_be    = 4'hF;
      mem_dw0                = make_dw0(3'b010, TYPE_MEM, 10'd1);
      send_beat(make_dw0(3'b010, TYPE_MEM, 10'd4), req_be, 3'd1, 1'b1);
      send_beat(cpl_dw0, cpl_ur, 3'd1, 1'b0);
      read_reg(REG_ERR_CODE, rd);
      expect_value("REG_ERR_CODE", rd, 0);

      pf = 3'($urandom_range(7, 0));
      send_beat(cpl_dw0, cpl_ur, pf, 1'b1);
      read_reg(REG_ERR_CODE, rd);
      expect_value("REG_ERR_CODE", rd, 32'h1 << ERR_BAD_CPL_STATUS);
      wait_log({25'h0, pf, 4'b0001});
      pf = 3'($urandom_range(7, 0));
      send_beat(mem_dw0, req_be, pf, 1'b1);
      read_reg(REG_ERR_CODE, rd);
      expect_value("REG_ERR_CODE", rd, 32'h3);
      wait_log({25'h0, pf, 4'b0010});
      pf = 3'($urandom_range(7, 0));
      send_beat(make_dw0(3'b000, 5'b00100, 10'd1), req_be, pf, 1'b1);
      read_reg(REG_ERR_CODE, rd);
      expect_value("REG_ERR_CODE", rd, 32'h7);
      wait_log({25'h0, pf, 4'b0100});
      read_reg(REG_ERR_HDR0, rd);
      expect_value("REG_ERR_HDR0", rd, cpl_dw0);
      read_reg(REG_ERR_HDR1, rd);
      expect_value("REG_ERR_HDR1", rd, cpl_ur);
      write_reg(REG_ERR_CODE, 32'hF);
      read_reg(REG_ERR_CODE, rd);
      expect_value("REG_ERR_CODE", rd, 0);

      // Completion timeout logs its tag
      tag               = 8'($urandom_range(255, 0));
      i_cpl_timeout     = 1'b1;
      i_cpl_timeout_tag = tag;
      @(negedge csr_clk);
      i_cpl_timeout = 1'b0;
      @(negedge csr_clk);
      read_reg(REG_ERR_CODE, rd);
      expect_value("REG_ERR_CODE", rd, 32'h1 << ERR_CPL_TIMEOUT);
      read_reg(REG_ERR_HDR1, rd);
      expect_value("REG_ERR_HDR1", rd, {24'h0, tag});
      wait_log(32'h8);
      write_reg(REG_ERR_CODE, 32'hF);

      // Indirect write and read back
      ss_addr = 16'($urandom_range(127, 0) * 4);
      if (ss_addr == SS_ERR_LOG_ADDR) begin
         ss_addr = 16'h0004;
      end
      ss_data = $urandom();
      write_reg(REG_SS_ADDR, ss_addr);
      write_reg(REG_SS_WDATA, ss_data);
      acks_before = acked_addr.size();
      write_reg(REG_SS_CMD, SS_CMD_WR);
      read_reg(REG_STATUS, rd);
      expect_value("REG_STATUS.busy", rd[1], 1);
      wait_idle("indirect write");
      assert (acked_addr.size() > acks_before)
         else log_failure("busy cleared before the SS acked the write");
      write_reg(REG_SS_CMD, SS_CMD_RD);
      wait_idle("indirect read");
      read_reg(REG_SS_RDATA, rd);
      expect_value("REG_SS_RDATA", rd, ss_data);
      read_reg(REG_STATUS, rd);
      expect_value("REG_STATUS.ss_err", rd[2], 0);

      // Out of range access sets the sticky SS error
      write_reg(REG_SS_ADDR, 16'h0200 + 16'($urandom_range(255, 0)));
      write_reg(REG_SS_CMD, SS_CMD_RD);
      wait_idle("out of range read");
      read_reg(REG_STATUS, rd);
      expect_value("REG_STATUS.ss_err", rd[2], 1);
      write_reg(REG_STATUS, 32'h4);
      read_reg(REG_STATUS, rd);
      expect_value("REG_STATUS.ss_err", rd[2], 0);

      // Error report and host command raised together
      write_reg(REG_SS_ADDR, ss_addr);
      write_reg(REG_SS_WDATA, $urandom());
      acked_addr.delete();
      pf                = 3'($urandom_range(7, 0));
      i_csr_wr          = 1'b1;
      i_csr_addr        = REG_SS_CMD;
      i_csr_wdata       = SS_CMD_WR;
      i_tx_valid        = 1'b1;
      i_tx_hdr_dw0      = cpl_dw0;
      i_tx_hdr_dw1      = cpl_ur;
      i_tx_pf           = pf;
      i_cpl_timeout     = 1'b1;
      i_cpl_timeout_tag = 8'($urandom_range(255, 0));
      @(negedge csr_clk);
      i_csr_wr      = 1'b0;
      i_tx_valid    = 1'b0;
      i_cpl_timeout = 1'b0;
      wait_log({25'h0, pf, 4'b1001});
      wait_idle("host write behind an error report");
      expect_value("SS transaction count", acked_addr.size(), 2);
      if (acked_addr.size() >= 2) begin
         expect_value("first SS address", acked_addr[0], SS_ERR_LOG_ADDR);
         expect_value("second SS address", acked_addr[1], ss_addr);
      end

      $display("Checks done: %0d value errors, %0d other errors", mismatches, problems);
      if (mismatches + problems == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

endmodule : tb_pcie_ss_if

`default_nettype wire

// ==== tb.f ====
source/pcie_ss_pkg.sv
source/pcie_csr.sv
source/pcie_err_checker.sv
source/pcie_ss_csr_master.sv
source/pcie_ss_if.sv
tests/pcie_ss_model.sv
tests/tb_pcie_ss_if.sv
